/* common/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // bus and ram geometry
    localparam int XLEN      = 64;
    localparam int WORD_W    = 32;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;
    localparam int LANES     = WORD_W / 8;

    // address map
    localparam logic [XLEN-1:0] RAM_BASE      = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] RAM_TOP       = RAM_BASE + XLEN'(RAM_WORDS * LANES);
    localparam logic [XLEN-1:0] KEY_ADDR      = 64'h0000_0000_1000_0100;
    localparam logic [XLEN-1:0] MTIME_ADDR    = 64'h0000_0000_0200_BFF8;
    localparam logic [XLEN-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam logic [XLEN-1:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // plic block, offsets relative to PLIC_BASE
    localparam int PLIC_OW = 22;
    localparam logic [XLEN-1:0] PLIC_BASE = 64'h0000_0000_0C00_0000;
    localparam logic [PLIC_OW-1:0] PLIC_PENDING    = 22'h00_1000;
    localparam logic [PLIC_OW-1:0] PLIC_ENABLE     = 22'h00_2000;
    localparam logic [PLIC_OW-1:0] PLIC_THRESHOLD  = 22'h20_0000;
    localparam logic [PLIC_OW-1:0] PLIC_CLAIM      = 22'h20_0004;
    localparam logic [PLIC_OW-1:0] PLIC_EN_STRIDE  = 22'h00_0080;
    localparam logic [PLIC_OW-1:0] PLIC_CTX_STRIDE = 22'h00_1000;
    localparam logic [XLEN-1:0] PLIC_TOP =
        PLIC_BASE + XLEN'(PLIC_CLAIM) + XLEN'(PLIC_CTX_STRIDE) + 64'd4;

    localparam int PLIC_IDS    = 6;
    localparam int PLIC_ID_W   = 3;
    localparam int PLIC_CTX    = 2; // hart0 M and S contexts
    localparam int PRIO_W      = 3;
    localparam int UART_IRQ_ID = 1;

    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } ls_type_e;

    typedef enum logic [2:0] {
        RAM, KEY, MTIME, MTIMECMP, PLIC, NONE
    } target_e;

endpackage

`default_nettype wire

/* hdl/bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic [soc_pkg::XLEN-1:0]     bus_address,
    input  logic [soc_pkg::XLEN-1:0]     bus_write_data,
    input  logic [2:0]                   bus_ls_type,
    input  logic                         bus_read_enable,
    input  logic                         bus_write_enable,
    input  logic [7:0]                   key_ascii,
    input  logic [soc_pkg::XLEN-1:0]     ram_rdata,
    input  logic [soc_pkg::XLEN-1:0]     plic_rdata,
    input  logic [soc_pkg::XLEN-1:0]     mtime,
    input  logic [soc_pkg::XLEN-1:0]     mtimecmp,
    output logic [soc_pkg::XLEN-1:0]     bus_read_data,
    output logic                         bus_read_done,
    output logic                         bus_write_done,
    output logic                         ram_rd,
    output logic                         ram_wr,
    output logic                         ram_step,
    output logic [soc_pkg::RAM_AW+1:0]   ram_byte_addr,
    output soc_pkg::ls_type_e            ls_type,
    output logic [soc_pkg::XLEN-1:0]     wdata,
    output logic                         plic_rd,
    output logic                         plic_wr,
    output logic [soc_pkg::PLIC_OW-1:0]  plic_offset,
    output logic                         cmp_wr
);

    typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_STEP, S_FINISH} state_t;

    state_t                   state;
    logic                     op_rd;   // current request is a load
    logic [soc_pkg::XLEN-1:0] addr_q;
    soc_pkg::target_e         target;
    logic                     access;
    logic [soc_pkg::XLEN-1:0] rdata_mux;

    // full address compare lives only here
    always_comb begin
        if (addr_q >= soc_pkg::RAM_BASE && addr_q < soc_pkg::RAM_TOP) target = soc_pkg::RAM;
        else if (addr_q == soc_pkg::KEY_ADDR) target = soc_pkg::KEY;
        else if (addr_q == soc_pkg::MTIME_ADDR) target = soc_pkg::MTIME;
        else if (addr_q == soc_pkg::MTIMECMP_ADDR) target = soc_pkg::MTIMECMP;
        else if (addr_q >= soc_pkg::PLIC_BASE && addr_q < soc_pkg::PLIC_TOP) target = soc_pkg::PLIC;
        else target = soc_pkg::NONE; // tlb, cache flush and the rest
    end

    assign access = (state == S_ACCESS) || (state == S_STEP);

    assign ram_rd  = access && op_rd && (target == soc_pkg::RAM);
    assign ram_wr  = access && !op_rd && (target == soc_pkg::RAM);
    assign ram_step = (state == S_STEP); // high word of ld / sd
    assign plic_rd = (state == S_ACCESS) && op_rd && (target == soc_pkg::PLIC);
    assign plic_wr = (state == S_ACCESS) && !op_rd && (target == soc_pkg::PLIC);
    assign cmp_wr  = (state == S_ACCESS) && !op_rd && (target == soc_pkg::MTIMECMP);

    assign ram_byte_addr = addr_q[soc_pkg::RAM_AW+1:0]; // base is aligned
    assign plic_offset   = addr_q[soc_pkg::PLIC_OW-1:0];

    always_comb begin
        case (target)
            soc_pkg::RAM:      rdata_mux = ram_rdata;
            soc_pkg::KEY:      rdata_mux = {{(soc_pkg::XLEN-8){1'b0}}, key_ascii};
            soc_pkg::MTIME:    rdata_mux = mtime;
            soc_pkg::MTIMECMP: rdata_mux = mtimecmp;
            soc_pkg::PLIC:     rdata_mux = plic_rdata;
            default:           rdata_mux = '0; // unmapped reads zero
        endcase
    end

    // request payload, held until done
    always_ff @(posedge CLOCK_50) begin
        if (state == S_IDLE && (bus_read_enable || bus_write_enable)) begin
            addr_q  <= bus_address;
            ls_type <= soc_pkg::ls_type_e'(bus_ls_type);
            wdata   <= bus_write_data;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            op_rd          <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bus_read_enable || bus_write_enable) begin
                        state          <= S_ACCESS;
                        op_rd          <= bus_read_enable;
                        bus_read_done  <= !bus_read_enable;
                        bus_write_done <= !bus_write_enable;
                    end
                end
                S_ACCESS: begin
                    // doubleword ram access needs a second word
                    if (target == soc_pkg::RAM && ls_type == soc_pkg::LD) state <= S_STEP;
                    else state <= S_FINISH;
                end
                S_STEP: state <= S_FINISH;
                S_FINISH: begin
                    if (op_rd) bus_read_data <= rdata_mux;
                    bus_read_done  <= 1'b1;
                    bus_write_done <= 1'b1;
                    state          <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/bus_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  logic [soc_pkg::XLEN-1:0] bus_address,
    input  logic [soc_pkg::XLEN-1:0] bus_write_data,
    input  logic [2:0]               bus_ls_type,
    input  logic                     bus_read_enable,
    input  logic                     bus_write_enable,
    input  logic [7:0]               key_ascii,
    input  logic                     uart_irq,
    output logic [soc_pkg::XLEN-1:0] bus_read_data,
    output logic                     bus_read_done,
    output logic                     bus_write_done,
    output logic                     meip,
    output logic                     msip
);

    logic                        ram_rd, ram_wr, ram_step;
    logic [soc_pkg::RAM_AW+1:0]  ram_byte_addr;
    soc_pkg::ls_type_e           ls_type;
    logic [soc_pkg::XLEN-1:0]    wdata;
    logic                        plic_rd, plic_wr, cmp_wr;
    logic [soc_pkg::PLIC_OW-1:0] plic_offset;
    logic [soc_pkg::XLEN-1:0]    ram_rdata, plic_rdata, mtime, mtimecmp;

    bus_controller bus_controller_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .key_ascii        (key_ascii),
        .ram_rdata        (ram_rdata),
        .plic_rdata       (plic_rdata),
        .mtime            (mtime),
        .mtimecmp         (mtimecmp),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_rd           (ram_rd),
        .ram_wr           (ram_wr),
        .ram_step         (ram_step),
        .ram_byte_addr    (ram_byte_addr),
        .ls_type          (ls_type),
        .wdata            (wdata),
        .plic_rd          (plic_rd),
        .plic_wr          (plic_wr),
        .plic_offset      (plic_offset),
        .cmp_wr           (cmp_wr)
    );

    ram_port ram_port_inst (
        .CLOCK_50      (CLOCK_50),
        .ram_rd        (ram_rd),
        .ram_wr        (ram_wr),
        .ram_step      (ram_step),
        .ram_byte_addr (ram_byte_addr),
        .ls_type       (ls_type),
        .wdata         (wdata),
        .ram_rdata     (ram_rdata)
    );

    plic_regs plic_regs_inst (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .plic_rd     (plic_rd),
        .plic_wr     (plic_wr),
        .plic_offset (plic_offset),
        .wdata       (wdata),
        .uart_irq    (uart_irq),
        .plic_rdata  (plic_rdata),
        .meip        (meip),
        .msip        (msip)
    );

    machine_timer machine_timer_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cmp_wr   (cmp_wr),
        .wdata    (wdata),
        .mtime    (mtime),
        .mtimecmp (mtimecmp)
    );

endmodule

`default_nettype wire

/* hdl/machine_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module machine_timer (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  logic                     cmp_wr,
    input  logic [soc_pkg::XLEN-1:0] wdata,
    output logic [soc_pkg::XLEN-1:0] mtime,
    output logic [soc_pkg::XLEN-1:0] mtimecmp
);

    // mtime runs every clock, no bus write path
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            mtime    <= '0;
            mtimecmp <= soc_pkg::MTIMECMP_RESET;
        end else begin
            mtime <= mtime + 64'd1;
            if (cmp_wr) mtimecmp <= wdata; // full 64 bits
        end
    end

endmodule

`default_nettype wire

/* list.f */
common/soc_pkg.sv
hdl/bus_controller.sv
ram/ram_port.sv
plic/plic_regs.sv
hdl/machine_timer.sv
hdl/bus_fabric.sv
tests/bus_fabric_assertions.sv
tests/tb_bus_fabric.sv

/* plic/plic_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_regs (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    input  logic                        plic_rd,
    input  logic                        plic_wr,
    input  logic [soc_pkg::PLIC_OW-1:0] plic_offset,
    input  logic [soc_pkg::XLEN-1:0]    wdata,
    input  logic                        uart_irq,
    output logic [soc_pkg::XLEN-1:0]    plic_rdata,
    output logic                        meip,
    output logic                        msip
);

    logic [soc_pkg::PRIO_W-1:0]   prio_q  [soc_pkg::PLIC_IDS];
    logic [soc_pkg::PLIC_IDS-1:0] pending;
    logic [31:0]                  enable_q [soc_pkg::PLIC_CTX];
    logic [soc_pkg::PRIO_W-1:0]   thresh_q [soc_pkg::PLIC_CTX];
    logic [soc_pkg::PLIC_CTX-1:0] claim;
    logic [soc_pkg::PLIC_CTX-1:0] en_hit, th_hit, cl_hit;
    logic                         prio_hit;
    logic [soc_pkg::PLIC_ID_W-1:0] prio_id;
    logic                         irq_q;
    logic [soc_pkg::XLEN-1:0]     rd_val;

    assign prio_id  = plic_offset[2 +: soc_pkg::PLIC_ID_W];
    assign prio_hit = plic_offset < soc_pkg::PLIC_OW'(4 * soc_pkg::PLIC_IDS);

    // per-context register decode and claim value
    always_comb begin
        for (int c = 0; c < soc_pkg::PLIC_CTX; c++) begin
            en_hit[c] = plic_offset == soc_pkg::PLIC_OW'(soc_pkg::PLIC_ENABLE
                        + c * soc_pkg::PLIC_EN_STRIDE);
            th_hit[c] = plic_offset == soc_pkg::PLIC_OW'(soc_pkg::PLIC_THRESHOLD
                        + c * soc_pkg::PLIC_CTX_STRIDE);
            cl_hit[c] = plic_offset == soc_pkg::PLIC_OW'(soc_pkg::PLIC_CLAIM
                        + c * soc_pkg::PLIC_CTX_STRIDE);
            claim[c]  = pending[soc_pkg::UART_IRQ_ID] && enable_q[c][soc_pkg::UART_IRQ_ID];
        end
    end

    assign meip = claim[0];
    assign msip = claim[1];

    always_comb begin
        rd_val = '0;
        if (prio_hit) rd_val = soc_pkg::XLEN'(prio_q[prio_id]);
        if (plic_offset == soc_pkg::PLIC_PENDING) rd_val = soc_pkg::XLEN'(pending);
        for (int c = 0; c < soc_pkg::PLIC_CTX; c++) begin
            if (en_hit[c]) rd_val = soc_pkg::XLEN'(enable_q[c]);
            if (th_hit[c]) rd_val = soc_pkg::XLEN'(thresh_q[c]);
            if (cl_hit[c] && claim[c]) rd_val = soc_pkg::XLEN'(soc_pkg::UART_IRQ_ID);
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (plic_rd) plic_rdata <= rd_val;
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
            irq_q   <= 1'b0;
            for (int i = 0; i < soc_pkg::PLIC_IDS; i++) prio_q[i] <= '0;
            for (int c = 0; c < soc_pkg::PLIC_CTX; c++) begin
                enable_q[c] <= '0;
                thresh_q[c] <= '0;
            end
        end else begin
            irq_q <= uart_irq;
            if (plic_wr && prio_hit) prio_q[prio_id] <= wdata[soc_pkg::PRIO_W-1:0];
            for (int c = 0; c < soc_pkg::PLIC_CTX; c++) begin
                if (plic_wr && en_hit[c]) enable_q[c] <= wdata[31:0];
                if (plic_wr && th_hit[c]) thresh_q[c] <= wdata[soc_pkg::PRIO_W-1:0];
                // claim writes are ignored; a claim read retires the source
                if (plic_rd && cl_hit[c] && claim[c]) pending[soc_pkg::UART_IRQ_ID] <= 1'b0;
            end
            if (uart_irq && !irq_q) pending[soc_pkg::UART_IRQ_ID] <= 1'b1; // edge wins
        end
    end

endmodule

`default_nettype wire

/* ram/ram_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_port (
    input  logic                       CLOCK_50,
    input  logic                       ram_rd,
    input  logic                       ram_wr,
    input  logic                       ram_step,
    input  logic [soc_pkg::RAM_AW+1:0] ram_byte_addr,
    input  soc_pkg::ls_type_e          ls_type,
    input  logic [soc_pkg::XLEN-1:0]   wdata,
    output logic [soc_pkg::XLEN-1:0]   ram_rdata
);

    logic [soc_pkg::WORD_W-1:0] mem [soc_pkg::RAM_WORDS];

    logic [soc_pkg::RAM_AW-1:0] idx;
    logic [1:0]                 off;
    logic [soc_pkg::LANES-1:0]  be;
    logic [soc_pkg::WORD_W-1:0] wword;
    logic [soc_pkg::WORD_W-1:0] lo_q;  // low word, or the only word
    logic [soc_pkg::WORD_W-1:0] hi_q;
    logic [soc_pkg::WORD_W-1:0] shifted;

    assign off = ram_byte_addr[1:0];
    assign idx = ram_byte_addr[soc_pkg::RAM_AW+1:2]
               + {{(soc_pkg::RAM_AW-1){1'b0}}, ram_step};

    // lane enables and lane-replicated store data
    always_comb begin
        be    = '0;
        wword = wdata[soc_pkg::WORD_W-1:0];
        case (ls_type)
            soc_pkg::LB: begin
                be[off] = 1'b1;
                wword   = {4{wdata[7:0]}};
            end
            soc_pkg::LH: begin
                be    = off[1] ? 4'b1100 : 4'b0011; // offset 0 or 2 only
                wword = {2{wdata[15:0]}};
            end
            soc_pkg::LW: be = 4'b1111;
            soc_pkg::LD: begin
                be = 4'b1111;
                if (ram_step) wword = wdata[soc_pkg::XLEN-1:soc_pkg::WORD_W];
            end
            default: be = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (ram_wr) begin
            for (int i = 0; i < soc_pkg::LANES; i++) begin
                if (be[i]) mem[idx][8*i +: 8] <= wword[8*i +: 8];
            end
        end
        if (ram_rd && !ram_step) lo_q <= mem[idx];
        if (ram_rd && ram_step) hi_q <= mem[idx]; // second step of ld
    end

    assign shifted = lo_q >> {off, 3'b000};

    // extension uses the type and offset the controller still holds
    always_comb begin
        case (ls_type)
            soc_pkg::LB:  ram_rdata = {{56{shifted[7]}}, shifted[7:0]};
            soc_pkg::LBU: ram_rdata = {56'd0, shifted[7:0]};
            soc_pkg::LH:  ram_rdata = {{48{shifted[15]}}, shifted[15:0]};
            soc_pkg::LHU: ram_rdata = {48'd0, shifted[15:0]};
            soc_pkg::LW:  ram_rdata = {{32{lo_q[31]}}, lo_q};
            soc_pkg::LWU: ram_rdata = {32'd0, lo_q};
            soc_pkg::LD:  ram_rdata = {hi_q, lo_q};
            default:      ram_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the bus fabric testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bus_fabric -f list.f \
    -Mdir obj_dir -o tb_bus_fabric \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_bus_fabric 2>&1)"
echo "$out"

echo "$out" | grep -qx "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/bus_fabric_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_fabric_assertions (
    input logic CLOCK_50,
    input logic KEY0,
    input logic bus_read_enable,
    input logic bus_write_enable,
    input logic bus_read_done,
    input logic bus_write_done
);

    logic [3:0] low_run; // consecutive cycles with a done level low

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            low_run <= '0;
        end else if (bus_read_done && bus_write_done) begin
            low_run <= '0;
        end else if (low_run != 4'hf) begin
            low_run <= low_run + 4'd1;
        end
    end

    read_done_drops: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable && bus_read_done && bus_write_done) |=> !bus_read_done)
        else $error("read done still high after a read enable");

    write_done_drops: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_write_enable && bus_read_done && bus_write_done) |=> !bus_write_done)
        else $error("write done still high after a write enable");

    enables_exclusive: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
        else $error("read and write enable pulsed together");

    // checked on the first edge out of reset
    done_after_reset: assert property (@(posedge CLOCK_50)
        $rose(KEY0) |-> (bus_read_done && bus_write_done))
        else $error("done levels not high after reset");

    done_low_bounded: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        low_run <= 4'd3)
        else $error("done level low for more than 3 cycles");

endmodule

bind bus_controller bus_fabric_assertions bus_fabric_assertions_inst (
    .CLOCK_50         (CLOCK_50),
    .KEY0             (KEY0),
    .bus_read_enable  (bus_read_enable),
    .bus_write_enable (bus_write_enable),
    .bus_read_done    (bus_read_done),
    .bus_write_done   (bus_write_done)
);

`default_nettype wire

/* tests/tb_bus_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_fabric;

    localparam int RESET_CYCLES = 8;
    localparam int REGION_BYTES = 256; // ram window used by the random traffic
    localparam int NUM_STORES   = 84;
    localparam int NUM_LOADS    = 140;
    localparam longint WATCHDOG_NS = 400 * 5 * 20 + RESET_CYCLES * 20;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic [2:0]  bus_ls_type;
    logic        bus_read_enable;
    logic        bus_write_enable;
    logic [7:0]  key_ascii;
    logic        uart_irq;
    logic [63:0] bus_read_data;
    logic        bus_read_done;
    logic        bus_write_done;
    logic        meip;
    logic        msip;

    logic [7:0]  ref_mem [REGION_BYTES]; // byte model of the ram window
    logic [63:0] data;
    logic [63:0] rd;
    logic [63:0] t_first;
    logic [2:0]  lt;
    int          off;

    bus_fabric bus_fabric_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .key_ascii        (key_ascii),
        .uart_irq         (uart_irq),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip             (meip),
        .msip             (msip)
    );

    always #10 CLOCK_50 = ~CLOCK_50;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected 0x%h, got 0x%h",
                     $time, name, expected, actual);
            abort_run("a checked value did not match");
        end
    endtask

    // one request, inputs held until both done levels are back
    task automatic bus_access(input logic is_read, input logic [63:0] addr,
                              input logic [63:0] wr_data, input logic [2:0] ls,
                              output logic [63:0] rd_data);
        int cycles;
        int expected_cycles;
        cycles = 0;
        expected_cycles = 2;
        if ((addr - soc_pkg::RAM_BASE) < 64'(REGION_BYTES) && ls == 3'(soc_pkg::LD))
            expected_cycles = 3; // two ram words
        bus_address      = addr;
        bus_write_data   = wr_data;
        bus_ls_type      = ls;
        bus_read_enable  = is_read;
        bus_write_enable = !is_read;
        @(negedge CLOCK_50);
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        if (is_read) check_value("bus_read_done", 64'd0, 64'(bus_read_done));
        else check_value("bus_write_done", 64'd0, 64'(bus_write_done));
        while (!(bus_read_done && bus_write_done)) begin
            if (cycles > 10) abort_run("timeout: done never came back high");
            @(negedge CLOCK_50);
            cycles++;
        end
        check_value("done latency", 64'(expected_cycles), 64'(cycles));
        rd_data = bus_read_data;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] wr_data,
                             input logic [2:0] ls);
        logic [63:0] ignored;
        bus_access(1'b0, addr, wr_data, ls, ignored);
    endtask

    task automatic read_expect(input string name, input logic [63:0] addr,
                               input logic [2:0] ls, input logic [63:0] expected);
        logic [63:0] got;
        bus_access(1'b1, addr, 64'd0, ls, got);
        check_value(name, expected, got);
    endtask

    function automatic void model_store(input int offset, input logic [63:0] wr_data,
                                        input logic [2:0] ls);
        for (int i = 0; i < (1 << ls[1:0]); i++) begin
            ref_mem[offset + i] = wr_data[8*i +: 8];
        end
    endfunction

    function automatic logic [63:0] model_load(input int offset, input logic [2:0] ls);
        logic [63:0] value;
        int          nbytes;
        value  = '0;
        nbytes = 1 << ls[1:0];
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = ref_mem[offset + i]; // little endian
        end
        // signed loads copy the top bit of the field upward
        if (!ls[2] && nbytes < 8 && value[8*nbytes-1]) value = value | (~64'd0 << (8 * nbytes));
        return value;
    endfunction

    function automatic logic [63:0] ctx_addr(input logic [soc_pkg::PLIC_OW-1:0] base,
                                             input logic [soc_pkg::PLIC_OW-1:0] stride,
                                             input int ctx);
        return soc_pkg::PLIC_BASE + 64'(soc_pkg::PLIC_OW'(base + ctx * stride));
    endfunction

    // route the uart line to one context, raise it, claim it
    task automatic irq_flow(input int ctx);
        logic [63:0] irq_bit;
        logic [63:0] got;
        irq_bit = 64'd1 << soc_pkg::UART_IRQ_ID;
        for (int c = 0; c < 2; c++) begin
            bus_write(ctx_addr(soc_pkg::PLIC_ENABLE, soc_pkg::PLIC_EN_STRIDE, c),
                      (c == ctx) ? irq_bit : 64'd0, 3'(soc_pkg::LW));
        end
        uart_irq = 1'b1;
        @(negedge CLOCK_50); // pending follows the edge by one cycle
        check_value("meip", 64'(ctx == 0), 64'(meip));
        check_value("msip", 64'(ctx == 1), 64'(msip));
        read_expect("plic claim", ctx_addr(soc_pkg::PLIC_CLAIM, soc_pkg::PLIC_CTX_STRIDE, ctx),
                    3'(soc_pkg::LW), 64'(soc_pkg::UART_IRQ_ID));
        check_value("meip", 64'd0, 64'(meip));
        check_value("msip", 64'd0, 64'(msip));
        bus_access(1'b1, soc_pkg::PLIC_BASE + 64'(soc_pkg::PLIC_PENDING), 64'd0,
                   3'(soc_pkg::LW), got);
        check_value("pending bit 1", 64'd0, got & irq_bit);
        uart_irq = 1'b0;
        @(negedge CLOCK_50);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'hce1d951b));
        CLOCK_50         = 1'b0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_ascii        = '0;
        uart_irq         = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        check_value("bus_read_done", 64'd1, 64'(bus_read_done));
        check_value("bus_write_done", 64'd1, 64'(bus_write_done));
        check_value("bus_read_data", 64'd0, bus_read_data);
        check_value("meip", 64'd0, 64'(meip));
        check_value("msip", 64'd0, 64'(msip));

        // known contents for the whole window first
        for (int d = 0; d < REGION_BYTES / 8; d++) begin
            data = {$urandom, $urandom};
            bus_write(soc_pkg::RAM_BASE + 64'(8 * d), data, 3'(soc_pkg::LD));
            model_store(8 * d, data, 3'(soc_pkg::LD));
        end
        for (int i = 0; i < NUM_STORES; i++) begin
            lt   = 3'(i % 4);
            off  = int'($urandom % (REGION_BYTES >> lt[1:0])) << lt[1:0];
            data = {$urandom, $urandom};
            bus_write(soc_pkg::RAM_BASE + 64'(off), data, lt);
            model_store(off, data, lt);
        end
        for (int i = 0; i < NUM_LOADS; i++) begin
            lt  = 3'(i % 7);
            off = int'($urandom % (REGION_BYTES >> lt[1:0])) << lt[1:0];
            read_expect("bus_read_data", soc_pkg::RAM_BASE + 64'(off), lt, model_load(off, lt));
        end

        key_ascii = 8'($urandom);
        read_expect("keyboard", soc_pkg::KEY_ADDR, 3'(soc_pkg::LW), {56'd0, key_ascii});
        read_expect("unmapped read", 64'h0000_0000_3000_0000, 3'(soc_pkg::LD), 64'd0);
        bus_write(64'h0000_0000_0000_1000, {$urandom, $urandom}, 3'(soc_pkg::LD));

        read_expect("mtimecmp", soc_pkg::MTIMECMP_ADDR, 3'(soc_pkg::LD), soc_pkg::MTIMECMP_RESET);
        data = {$urandom, $urandom};
        bus_write(soc_pkg::MTIMECMP_ADDR, data, 3'(soc_pkg::LD));
        read_expect("mtimecmp", soc_pkg::MTIMECMP_ADDR, 3'(soc_pkg::LD), data);
        bus_access(1'b1, soc_pkg::MTIME_ADDR, 64'd0, 3'(soc_pkg::LD), t_first);
        bus_access(1'b1, soc_pkg::MTIME_ADDR, 64'd0, 3'(soc_pkg::LD), rd);
        assert (rd > t_first) else abort_run("mtime did not increase between two reads");

        for (int id = 0; id < soc_pkg::PLIC_IDS; id++) begin
            data = {$urandom, $urandom};
            bus_write(ctx_addr('0, 22'd4, id), data, 3'(soc_pkg::LW));
            read_expect("plic priority", ctx_addr('0, 22'd4, id), 3'(soc_pkg::LW),
                        data & 64'((1 << soc_pkg::PRIO_W) - 1));
        end
        for (int c = 0; c < 2; c++) begin
            data = {$urandom, $urandom};
            bus_write(ctx_addr(soc_pkg::PLIC_ENABLE, soc_pkg::PLIC_EN_STRIDE, c), data,
                      3'(soc_pkg::LW));
            read_expect("plic enable", ctx_addr(soc_pkg::PLIC_ENABLE, soc_pkg::PLIC_EN_STRIDE, c),
                        3'(soc_pkg::LW), data & 64'hffff_ffff);
            data = {$urandom, $urandom};
            bus_write(ctx_addr(soc_pkg::PLIC_THRESHOLD, soc_pkg::PLIC_CTX_STRIDE, c), data,
                      3'(soc_pkg::LW));
            read_expect("plic threshold",
                        ctx_addr(soc_pkg::PLIC_THRESHOLD, soc_pkg::PLIC_CTX_STRIDE, c),
                        3'(soc_pkg::LW), data & 64'((1 << soc_pkg::PRIO_W) - 1));
        end

        irq_flow(0);
        irq_flow(1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
